// ==== hw/avr_pkg.sv ====
`default_nettype none

package avr_pkg;

	localparam int DATA_W     = 8;
	localparam int INSN_W     = 16;
	localparam int REG_ADDR_W = 5;
	localparam int IO_ADDR_W  = 6;

	typedef logic [DATA_W-1:0]     data_t;
	typedef logic [INSN_W-1:0]     insn_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [IO_ADDR_W-1:0]  io_addr_t;
	typedef logic [7:0]            sreg_t;

	// Flag positions in SREG
	localparam int SREG_C = 0;
	localparam int SREG_Z = 1;
	localparam int SREG_N = 2;
	localparam int SREG_V = 3;
	localparam int SREG_S = 4;
	localparam int SREG_H = 5;
	localparam int SREG_T = 6;
	localparam int SREG_I = 7;

	localparam io_addr_t SREG_IO_ADDR = 6'h3F;

	typedef enum logic [4:0] {
		OP_NOP,
		OP_ADD,
		OP_ADC,
		OP_SUB,
		OP_SUBI,
		OP_CP,
		OP_AND,
		OP_ANDI,
		OP_OR,
		OP_EOR,
		OP_INC,
		OP_DEC,
		OP_LSR,
		OP_ROR,
		OP_SWAP,
		OP_MOV,
		OP_LDI,
		OP_BSET,
		OP_BCLR,
		OP_RJMP,
		OP_BRBS,
		OP_BRBC,
		OP_OUT
	} opcode_e;

	// Machine cycle
	typedef enum logic {
		PH_FETCH,
		PH_EXEC
	} phase_e;

endpackage

`default_nettype wire

// ==== hw/prog_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module prog_rom
#(
	parameter int PROG_ADDR_W = 10
)
(
	input  logic                   ALU_CLK,
	input  logic                   i_we,
	input  logic [PROG_ADDR_W-1:0] i_waddr,
	input  avr_pkg::insn_t         i_wdata,
	input  logic [PROG_ADDR_W-1:0] i_raddr,
	output avr_pkg::insn_t         o_insn
);
	import avr_pkg::*;

	insn_t mem [2**PROG_ADDR_W];

	always_ff @(posedge ALU_CLK)
	begin
		if (i_we)
			mem[i_waddr] <= i_wdata; // Programming port
		o_insn <= mem[i_raddr];
	end

endmodule

`default_nettype wire

// ==== hw/op_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module op_decoder
(
	input  avr_pkg::insn_t     i_insn,
	output avr_pkg::opcode_e   o_op,
	output avr_pkg::reg_addr_t o_rd,
	output avr_pkg::reg_addr_t o_rr,
	output avr_pkg::data_t     o_imm,
	output logic [2:0]         o_bit,
	output avr_pkg::io_addr_t  o_io_addr,
	output logic signed [11:0] o_offset
);
	import avr_pkg::*;

	logic imm_form;

	always_comb
	begin
		o_op = OP_NOP;
		case (i_insn[15:12])
			4'h0: if (i_insn[11:10] == 2'b11) o_op = OP_ADD;
			4'h1:
			begin
				case (i_insn[11:10])
					2'b01:   o_op = OP_CP;
					2'b10:   o_op = OP_SUB;
					2'b11:   o_op = OP_ADC;
					default: o_op = OP_NOP; // CPSE not kept
				endcase
			end
			4'h2:
			begin
				case (i_insn[11:10])
					2'b00:   o_op = OP_AND;
					2'b01:   o_op = OP_EOR;
					2'b10:   o_op = OP_OR;
					default: o_op = OP_MOV;
				endcase
			end
			4'h5: o_op = OP_SUBI;
			4'h7: o_op = OP_ANDI;
			4'h9:
			begin
				// One-operand group 1001 010x
				if (i_insn[11:9] == 3'b010)
				begin
					case (i_insn[3:0])
						4'h2:    o_op = OP_SWAP;
						4'h3:    o_op = OP_INC;
						4'h6:    o_op = OP_LSR;
						4'h7:    o_op = OP_ROR;
						4'hA:    o_op = OP_DEC;
						4'h8:    if (!i_insn[8]) o_op = i_insn[7] ? OP_BCLR : OP_BSET;
						default: o_op = OP_NOP;
					endcase
				end
			end
			4'hB: if (i_insn[11]) o_op = OP_OUT;
			4'hC: o_op = OP_RJMP;
			4'hE: o_op = OP_LDI;
			4'hF: if (!i_insn[11]) o_op = i_insn[10] ? OP_BRBC : OP_BRBS;
			default: o_op = OP_NOP;
		endcase
	end

	assign imm_form = (o_op == OP_SUBI) || (o_op == OP_ANDI) || (o_op == OP_LDI);

	assign o_rd      = imm_form ? {1'b1, i_insn[7:4]} : i_insn[8:4]; // r16..r31 for immediates
	assign o_rr      = {i_insn[9], i_insn[3:0]};
	assign o_imm     = {i_insn[11:8], i_insn[3:0]};
	assign o_io_addr = {i_insn[10:9], i_insn[3:0]};
	assign o_bit     = ((o_op == OP_BSET) || (o_op == OP_BCLR)) ? i_insn[6:4] : i_insn[2:0];

	// 12-bit for RJMP, 7-bit for conditional branches
	assign o_offset = (o_op == OP_RJMP) ? i_insn[11:0] : {{5{i_insn[9]}}, i_insn[9:3]};

endmodule

`default_nettype wire

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file
(
	input  logic               ALU_CLK,
	input  logic               hclk,
	input  logic               i_we,
	input  avr_pkg::reg_addr_t i_waddr,
	input  avr_pkg::data_t     i_wdata,
	input  avr_pkg::reg_addr_t i_raddr_a,
	input  avr_pkg::reg_addr_t i_raddr_b,
	output avr_pkg::data_t     o_rdata_a,
	output avr_pkg::data_t     o_rdata_b
);
	import avr_pkg::*;

	localparam int NREGS = 2 ** REG_ADDR_W;

	data_t regs [NREGS];

	always_ff @(posedge ALU_CLK or posedge hclk)
	begin
		if (hclk)
		begin
			for (int i = 0; i < NREGS; i++)
				regs[i] <= '0;
		end
		else if (i_we)
			regs[i_waddr] <= i_wdata;
	end

	assign o_rdata_a = regs[i_raddr_a];
	assign o_rdata_b = regs[i_raddr_b];

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu
(
	input  avr_pkg::opcode_e i_op,
	input  avr_pkg::data_t   i_a,
	input  avr_pkg::data_t   i_b,
	input  avr_pkg::data_t   i_imm,
	input  logic [2:0]       i_bit,
	input  avr_pkg::sreg_t   i_sreg,
	output avr_pkg::data_t   o_result,
	output logic             o_wb,
	output avr_pkg::sreg_t   o_sreg_next
);
	import avr_pkg::*;

	localparam int MSB = DATA_W - 1;

	data_t opb;
	data_t res;
	sreg_t sn;
	logic  cin;
	logic  wb;
	logic  upd_nzs;

	// Carry or borrow out of a bit position
	function automatic logic add_carry(input logic a, input logic b, input logic r);
		return (a & b) | (b & ~r) | (~r & a);
	endfunction

	function automatic logic sub_borrow(input logic a, input logic b, input logic r);
		return (~a & b) | (b & r) | (r & ~a);
	endfunction

	function automatic logic add_ovf(input logic a, input logic b, input logic r);
		return (a & b & ~r) | (~a & ~b & r);
	endfunction

	function automatic logic sub_ovf(input logic a, input logic b, input logic r);
		return (a & ~b & ~r) | (~a & b & r);
	endfunction

	assign opb = ((i_op == OP_SUBI) || (i_op == OP_ANDI) || (i_op == OP_LDI)) ? i_imm : i_b;
	assign cin = (i_op == OP_ADC) ? i_sreg[SREG_C] : 1'b0;

	always_comb
	begin
		res     = i_a;
		sn      = i_sreg; // Untouched flags pass through
		wb      = 1'b1;
		upd_nzs = 1'b1;
		case (i_op)
			OP_ADD, OP_ADC:
			begin
				res        = i_a + opb + cin;
				sn[SREG_H] = add_carry(i_a[3], opb[3], res[3]);
				sn[SREG_C] = add_carry(i_a[MSB], opb[MSB], res[MSB]);
				sn[SREG_V] = add_ovf(i_a[MSB], opb[MSB], res[MSB]);
			end
			OP_SUB, OP_SUBI, OP_CP:
			begin
				res        = i_a - opb;
				sn[SREG_H] = sub_borrow(i_a[3], opb[3], res[3]);
				sn[SREG_C] = sub_borrow(i_a[MSB], opb[MSB], res[MSB]);
				sn[SREG_V] = sub_ovf(i_a[MSB], opb[MSB], res[MSB]);
				wb         = (i_op != OP_CP); // Compare only
			end
			OP_AND, OP_ANDI, OP_OR, OP_EOR:
			begin
				if (i_op == OP_OR)
					res = i_a | opb;
				else if (i_op == OP_EOR)
					res = i_a ^ opb;
				else
					res = i_a & opb;
				sn[SREG_V] = 1'b0;
			end
			OP_INC:
			begin
				res        = i_a + 1'b1;
				sn[SREG_V] = (res == 8'h80);
			end
			OP_DEC:
			begin
				res        = i_a - 1'b1;
				sn[SREG_V] = (res == 8'h7F);
			end
			OP_LSR, OP_ROR:
			begin
				res        = {(i_op == OP_ROR) & i_sreg[SREG_C], i_a[MSB:1]};
				sn[SREG_C] = i_a[0];
				sn[SREG_V] = res[MSB] ^ i_a[0]; // N xor C
			end
			OP_SWAP:
			begin
				res     = {i_a[3:0], i_a[MSB:4]};
				upd_nzs = 1'b0;
			end
			OP_MOV, OP_LDI:
			begin
				res     = opb;
				upd_nzs = 1'b0;
			end
			OP_BSET, OP_BCLR:
			begin
				sn[i_bit] = (i_op == OP_BSET);
				wb        = 1'b0;
				upd_nzs   = 1'b0;
			end
			default:
			begin
				wb      = 1'b0;
				upd_nzs = 1'b0;
			end
		endcase

		if (upd_nzs)
		begin
			sn[SREG_N] = res[MSB];
			sn[SREG_Z] = (res == '0);
			sn[SREG_S] = res[MSB] ^ sn[SREG_V];
		end
	end

	assign o_result    = res;
	assign o_wb        = wb;
	assign o_sreg_next = sn;

endmodule

`default_nettype wire

// ==== hw/core_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_ctrl
#(
	parameter int PROG_ADDR_W = 10
)
(
	input  logic                   ALU_CLK,
	input  logic                   hclk,
	input  logic                   i_run,
	input  avr_pkg::opcode_e       i_op,
	input  logic signed [11:0]     i_offset,
	input  logic [2:0]             i_bit,
	input  avr_pkg::io_addr_t      i_io_addr,
	input  avr_pkg::data_t         i_src,
	input  logic                   i_wb,
	input  avr_pkg::sreg_t         i_sreg_next,
	output logic                   o_rf_we,
	output logic [PROG_ADDR_W-1:0] o_fetch_addr,
	output avr_pkg::sreg_t         o_sreg,
	output logic [PROG_ADDR_W-1:0] o_pc,
	output logic                   o_io_we,
	output avr_pkg::io_addr_t      o_io_addr,
	output avr_pkg::data_t         o_io_data
);
	import avr_pkg::*;

	phase_e                 phase;
	logic [PROG_ADDR_W-1:0] pc;
	logic [PROG_ADDR_W-1:0] pc_inc;
	logic [PROG_ADDR_W-1:0] pc_rel;
	logic [PROG_ADDR_W-1:0] pc_next;
	sreg_t                  sreg;
	logic                   exec;
	logic                   taken;
	logic                   out_sreg;

	assign exec   = (phase == PH_EXEC);
	assign pc_inc = pc + 1'b1;
	assign pc_rel = pc_inc + PROG_ADDR_W'(i_offset); // Sign extends or wraps

	assign taken = (i_op == OP_RJMP) ||
		((i_op == OP_BRBS) && sreg[i_bit]) ||
		((i_op == OP_BRBC) && !sreg[i_bit]);
	assign pc_next = taken ? pc_rel : pc_inc;

	assign out_sreg = (i_op == OP_OUT) && (i_io_addr == SREG_IO_ADDR);

	always_ff @(posedge ALU_CLK or posedge hclk)
	begin
		if (hclk)
		begin
			phase     <= PH_FETCH;
			pc        <= '0;
			sreg      <= '0;
			o_io_we   <= 1'b0;
			o_io_addr <= '0;
			o_io_data <= '0;
		end
		else
		begin
			o_io_we <= 1'b0; // Single-cycle strobe
			if (exec)
			begin
				phase <= PH_FETCH;
				pc    <= pc_next;
				sreg  <= out_sreg ? i_src : i_sreg_next;
				if ((i_op == OP_OUT) && !out_sreg)
				begin
					o_io_we   <= 1'b1;
					o_io_addr <= i_io_addr;
					o_io_data <= i_src;
				end
			end
			else if (i_run)
				phase <= PH_EXEC;
		end
	end

	assign o_rf_we      = exec && i_wb;
	assign o_fetch_addr = pc;
	assign o_pc         = pc;
	assign o_sreg       = sreg;

endmodule

`default_nettype wire

// ==== hw/avr_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module avr_core
#(
	parameter int PROG_ADDR_W = 10
)
(
	input  logic                   ALU_CLK,
	input  logic                   hclk,
	input  logic                   i_run,
	input  logic                   i_prog_we,
	input  logic [PROG_ADDR_W-1:0] i_prog_addr,
	input  avr_pkg::insn_t         i_prog_data,
	output logic                   o_io_we,
	output avr_pkg::io_addr_t      o_io_addr,
	output avr_pkg::data_t         o_io_data,
	output avr_pkg::sreg_t         o_sreg,
	output logic [PROG_ADDR_W-1:0] o_pc
);
	import avr_pkg::*;

	insn_t                  insn;
	opcode_e                op;
	reg_addr_t              rd;
	reg_addr_t              rr;
	data_t                  imm;
	logic [2:0]             bit_sel;
	io_addr_t               dec_io_addr;
	logic signed [11:0]     offset;
	data_t                  rdata_a;
	data_t                  rdata_b;
	data_t                  alu_result;
	logic                   alu_wb;
	sreg_t                  sreg_next;
	logic                   rf_we;
	logic [PROG_ADDR_W-1:0] fetch_addr;

	prog_rom #(.PROG_ADDR_W(PROG_ADDR_W)) prog_rom_i (
		.ALU_CLK (ALU_CLK),
		.i_we    (i_prog_we),
		.i_waddr (i_prog_addr),
		.i_wdata (i_prog_data),
		.i_raddr (fetch_addr),
		.o_insn  (insn)
	);

	op_decoder op_decoder_i (
		.i_insn    (insn),
		.o_op      (op),
		.o_rd      (rd),
		.o_rr      (rr),
		.o_imm     (imm),
		.o_bit     (bit_sel),
		.o_io_addr (dec_io_addr),
		.o_offset  (offset)
	);

	reg_file reg_file_i (
		.ALU_CLK   (ALU_CLK),
		.hclk      (hclk),
		.i_we      (rf_we),
		.i_waddr   (rd),
		.i_wdata   (alu_result),
		.i_raddr_a (rd),
		.i_raddr_b (rr),
		.o_rdata_a (rdata_a),
		.o_rdata_b (rdata_b)
	);

	alu alu_i (
		.i_op        (op),
		.i_a         (rdata_a),
		.i_b         (rdata_b),
		.i_imm       (imm),
		.i_bit       (bit_sel),
		.i_sreg      (o_sreg),
		.o_result    (alu_result),
		.o_wb        (alu_wb),
		.o_sreg_next (sreg_next)
	);

	// OUT source register sits in the Rd field
	core_ctrl #(.PROG_ADDR_W(PROG_ADDR_W)) core_ctrl_i (
		.ALU_CLK      (ALU_CLK),
		.hclk         (hclk),
		.i_run        (i_run),
		.i_op         (op),
		.i_offset     (offset),
		.i_bit        (bit_sel),
		.i_io_addr    (dec_io_addr),
		.i_src        (rdata_a),
		.i_wb         (alu_wb),
		.i_sreg_next  (sreg_next),
		.o_rf_we      (rf_we),
		.o_fetch_addr (fetch_addr),
		.o_sreg       (o_sreg),
		.o_pc         (o_pc),
		.o_io_we      (o_io_we),
		.o_io_addr    (o_io_addr),
		.o_io_data    (o_io_data)
	);

endmodule

`default_nettype wire

// ==== testbench/avr_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module avr_core_tb;
	import avr_pkg::*;

	localparam int PROG_ADDR_W = 10;

	logic                   ALU_CLK;
	logic                   hclk;
	logic                   i_run;
	logic                   i_prog_we;
	logic [PROG_ADDR_W-1:0] i_prog_addr;
	insn_t                  i_prog_data;
	logic                   o_io_we;
	io_addr_t               o_io_addr;
	data_t                  o_io_data;
	sreg_t                  o_sreg;
	logic [PROG_ADDR_W-1:0] o_pc;

	insn_t       prog [$];
	io_addr_t    exp_addr [$];
	data_t       exp_data [$];
	sreg_t       exp_sreg [$];
	sreg_t       model_sreg;
	logic [31:0] lfsr_state;
	int          cycle_limit = 100;
	int          total_cycles = 0;

	avr_core #(.PROG_ADDR_W(PROG_ADDR_W)) dut_i (
		.ALU_CLK     (ALU_CLK),
		.hclk        (hclk),
		.i_run       (i_run),
		.i_prog_we   (i_prog_we),
		.i_prog_addr (i_prog_addr),
		.i_prog_data (i_prog_data),
		.o_io_we     (o_io_we),
		.o_io_addr   (o_io_addr),
		.o_io_data   (o_io_data),
		.o_sreg      (o_sreg),
		.o_pc        (o_pc)
	);

	initial
	begin
		ALU_CLK = 1'b0;
		forever #2 ALU_CLK = ~ALU_CLK;
	end

	task automatic stop_on_error();
		$display("Test FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_data(input string name, input data_t got, input data_t want);
		if (got !== want)
		begin
			$display("ERR @%0t %s: got %h, expected %h", $time, name, got, want);
			stop_on_error();
		end
	endtask

	task automatic check_io_addr(input string name, input io_addr_t got, input io_addr_t want);
		if (got !== want)
		begin
			$display("ERR @%0t %s: got %h, expected %h", $time, name, got, want);
			stop_on_error();
		end
	endtask

	task automatic check_sreg(input string name, input sreg_t got, input sreg_t want);
		if (got !== want)
		begin
			$display("ERR @%0t %s: got %b, expected %b", $time, name, got, want);
			stop_on_error();
		end
	endtask

	task automatic check_pc(input string name, input logic [PROG_ADDR_W-1:0] got,
		input logic [PROG_ADDR_W-1:0] want);
		if (got !== want)
		begin
			$display("ERR @%0t %s: got %0d, expected %0d", $time, name, got, want);
			stop_on_error();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic want);
		if (got !== want)
		begin
			$display("ERR @%0t %s: got %b, expected %b", $time, name, got, want);
			stop_on_error();
		end
	endtask

	task automatic check_cycles(input string name, input int got, input int want);
		if (got != want)
		begin
			$display("ERR @%0t %s: got %0d, expected %0d", $time, name, got, want);
			stop_on_error();
		end
	endtask

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic insn_t enc_two_reg(input logic [5:0] opc, input reg_addr_t d,
		input reg_addr_t r);
		return {opc, r[4], d, r[3:0]};
	endfunction

	function automatic insn_t enc_imm(input logic [3:0] opc, input reg_addr_t d, input data_t k);
		return {opc, k[7:4], d[3:0], k[3:0]}; // Rd is r16..r31
	endfunction

	function automatic insn_t enc_one_reg(input reg_addr_t d, input logic [3:0] sub);
		return {7'b1001010, d, sub};
	endfunction

	function automatic insn_t enc_out(input io_addr_t a, input reg_addr_t r);
		return {5'b10111, a[5:4], r, a[3:0]};
	endfunction

	function automatic insn_t enc_flag(input logic clr, input logic [2:0] s);
		return {8'h94, clr, s, 4'h8};
	endfunction

	function automatic insn_t enc_branch(input logic clr, input logic [6:0] k, input logic [2:0] s);
		return {4'hF, 1'b0, clr, k, s};
	endfunction

	function automatic void push_marker(input data_t v);
		prog.push_back(enc_imm(4'hE, 5'd16, v));
		prog.push_back(enc_out(6'h01, 5'd16));
	endfunction

	function automatic sreg_t set_nzs(input sreg_t f, input data_t res);
		sreg_t g;
		g = f;
		g[SREG_N] = res[7];
		g[SREG_Z] = (res == 8'h00);
		g[SREG_S] = res[7] ^ g[SREG_V];
		return g;
	endfunction

	function automatic sreg_t add_flags(input sreg_t f, input data_t a, input data_t b,
		input logic cin);
		sreg_t g;
		data_t res;
		g = f;
		res = a + b + cin;
		g[SREG_C] = (int'(a) + int'(b) + cin) > 255;
		g[SREG_H] = (a[3:0] + b[3:0] + cin) > 15;
		g[SREG_V] = (a[7] == b[7]) && (res[7] != a[7]);
		return set_nzs(g, res);
	endfunction

	function automatic sreg_t sub_flags(input sreg_t f, input data_t a, input data_t b);
		sreg_t g;
		data_t res;
		g = f;
		res = a - b;
		g[SREG_C] = (a < b);
		g[SREG_H] = (a[3:0] < b[3:0]);
		g[SREG_V] = (a[7] != b[7]) && (res[7] != a[7]);
		return set_nzs(g, res);
	endfunction

	function automatic sreg_t logic_flags(input sreg_t f, input data_t res);
		sreg_t g;
		g = f;
		g[SREG_V] = 1'b0;
		return set_nzs(g, res);
	endfunction

	function automatic sreg_t shift_flags(input sreg_t f, input data_t res, input logic c);
		sreg_t g;
		g = f;
		g[SREG_C] = c;
		g[SREG_V] = res[7] ^ c;
		return set_nzs(g, res);
	endfunction

	// Instruction-level model that stops at the halt loop in the last word
	function automatic int run_model();
		data_t     r [32];
		sreg_t     sr;
		insn_t     w;
		data_t     a;
		data_t     b;
		data_t     k;
		data_t     res;
		reg_addr_t d;
		reg_addr_t dh;
		io_addr_t  io;
		logic      cin;
		int        pc;
		int        steps;
		int        off;
		sr = '0;
		pc = 0;
		steps = 0;
		foreach (r[i])
			r[i] = '0;
		while ((pc != prog.size() - 1) && (steps < 4096))
		begin
			w  = prog[pc];
			d  = w[8:4];
			dh = {1'b1, w[7:4]};
			a  = r[d];
			b  = r[{w[9], w[3:0]}];
			k  = {w[11:8], w[3:0]};
			pc++;
			steps++;
			casez (w)
				16'b0000_11??_????_????, 16'b0001_11??_????_????:
				begin
					cin  = w[12] & sr[SREG_C]; // ADC only
					sr   = add_flags(sr, a, b, cin);
					r[d] = a + b + cin;
				end
				16'b0001_10??_????_????:
				begin
					sr   = sub_flags(sr, a, b);
					r[d] = a - b;
				end
				16'b0001_01??_????_????: sr = sub_flags(sr, a, b);
				16'b0101_????_????_????:
				begin
					sr    = sub_flags(sr, r[dh], k);
					r[dh] = r[dh] - k;
				end
				16'b0010_00??_????_????:
				begin
					r[d] = a & b;
					sr   = logic_flags(sr, r[d]);
				end
				16'b0111_????_????_????:
				begin
					r[dh] = r[dh] & k;
					sr    = logic_flags(sr, r[dh]);
				end
				16'b0010_10??_????_????:
				begin
					r[d] = a | b;
					sr   = logic_flags(sr, r[d]);
				end
				16'b0010_01??_????_????:
				begin
					r[d] = a ^ b;
					sr   = logic_flags(sr, r[d]);
				end
				16'b0010_11??_????_????: r[d] = b;
				16'b1110_????_????_????: r[dh] = k;
				16'b1001_010?_????_0010: r[d] = {a[3:0], a[7:4]};
				16'b1001_010?_????_0011:
				begin
					res        = a + 8'h01;
					sr[SREG_V] = (a == 8'h7F);
					sr         = set_nzs(sr, res);
					r[d]       = res;
				end
				16'b1001_010?_????_1010:
				begin
					res        = a - 8'h01;
					sr[SREG_V] = (a == 8'h80);
					sr         = set_nzs(sr, res);
					r[d]       = res;
				end
				16'b1001_010?_????_0110:
				begin
					r[d] = {1'b0, a[7:1]};
					sr   = shift_flags(sr, r[d], a[0]);
				end
				16'b1001_010?_????_0111:
				begin
					r[d] = {sr[SREG_C], a[7:1]};
					sr   = shift_flags(sr, r[d], a[0]);
				end
				16'b1001_0100_0???_1000: sr[w[6:4]] = 1'b1;
				16'b1001_0100_1???_1000: sr[w[6:4]] = 1'b0;
				16'b1100_????_????_????:
				begin
					off = int'($signed(w[11:0]));
					pc  = pc + off;
				end
				16'b1111_0???_????_????:
				begin
					off = int'($signed(w[9:3]));
					if (sr[w[2:0]] != w[10])
						pc = pc + off; // Bit matches the branch sense
				end
				16'b1011_1???_????_????:
				begin
					io = {w[10:9], w[3:0]};
					if (io == SREG_IO_ADDR)
						sr = a;
					else
					begin
						exp_addr.push_back(io);
						exp_data.push_back(a);
						exp_sreg.push_back(sr);
					end
				end
				default: ; // Anything else runs as NOP
			endcase
		end
		model_sreg = sr;
		return steps;
	endfunction

	task automatic gen_alu_program();
		reg_addr_t d;
		reg_addr_t r;
		data_t     k;
		io_addr_t  port;
		int        sel;
		prog.delete();
		for (int i = 16; i < 32; i++)
			prog.push_back(enc_imm(4'hE, reg_addr_t'(i), data_t'(rand_bits(8))));
		for (int i = 0; i < 40; i++)
		begin
			d   = reg_addr_t'(rand_bits(5));
			r   = reg_addr_t'(rand_bits(5));
			k   = data_t'(rand_bits(8));
			sel = int'(rand_bits(4)) % 15;
			if (sel == 3 || sel == 7)
				d[4] = 1'b1;
			case (sel)
				0:       prog.push_back(enc_two_reg(6'b000011, d, r));
				1:       prog.push_back(enc_two_reg(6'b000111, d, r));
				2:       prog.push_back(enc_two_reg(6'b000110, d, r));
				3:       prog.push_back(enc_imm(4'h5, d, k));
				4:       prog.push_back(enc_two_reg(6'b000101, d, r));
				5:       prog.push_back(enc_two_reg(6'b001000, d, r));
				6:       prog.push_back(enc_two_reg(6'b001010, d, r));
				7:       prog.push_back(enc_imm(4'h7, d, k));
				8:       prog.push_back(enc_two_reg(6'b001001, d, r));
				9:       prog.push_back(enc_one_reg(d, 4'h3));
				10:      prog.push_back(enc_one_reg(d, 4'hA));
				11:      prog.push_back(enc_one_reg(d, 4'h6));
				12:      prog.push_back(enc_one_reg(d, 4'h7));
				13:      prog.push_back(enc_one_reg(d, 4'h2));
				default: prog.push_back(enc_two_reg(6'b001011, d, r));
			endcase
			port = io_addr_t'(rand_bits(6));
			if (port == SREG_IO_ADDR)
				port = 6'h00;
			prog.push_back(enc_out(port, d));
		end
		prog.push_back(16'hCFFF);
	endtask

	task automatic gen_branch_program();
		logic [2:0] s;
		data_t      m;
		prog.delete();
		prog.push_back(16'hC002); // Over the first marker
		push_marker(8'hEE);
		prog.push_back(16'hC003);
		push_marker(8'hA5);
		prog.push_back(16'hC003);
		push_marker(8'h5A);
		prog.push_back(16'hCFFA); // Back to the A5 marker
		m = 8'h01;
		for (int i = 0; i < 16; i++)
		begin
			s = 3'(rand_bits(3));
			prog.push_back(enc_flag(rand_bits(1) != 0, s));
			prog.push_back(enc_branch(rand_bits(1) != 0, 7'd2, s));
			push_marker(m);
			m++;
		end
		for (int i = 0; i < 8; i++)
		begin
			prog.push_back(enc_imm(4'hE, 5'd17, data_t'(rand_bits(8))));
			prog.push_back(enc_out(SREG_IO_ADDR, 5'd17));
			prog.push_back(enc_branch(rand_bits(1) != 0, 7'd2, 3'(rand_bits(3))));
			push_marker(m);
			m++;
		end
		prog.push_back(16'hCFFF);
	endtask

	task automatic gen_nop_program();
		int n;
		prog.delete();
		prog.push_back(enc_imm(4'hE, 5'd20, data_t'(rand_bits(8))));
		for (int i = 0; i < 10; i++)
		begin
			n = int'(rand_bits(2)) + 1;
			repeat (n)
				prog.push_back((rand_bits(1) != 0) ? 16'hFFFF : 16'h0000);
			prog.push_back(enc_out(6'h05, 5'd20));
			prog.push_back(enc_one_reg(5'd20, 4'h3));
		end
		prog.push_back(16'hCFFF);
	endtask

	task automatic apply_reset();
		@(posedge ALU_CLK);
		#1;
		i_run = 1'b0;
		hclk  = 1'b1;
		repeat (5)
			@(posedge ALU_CLK);
		#1 hclk = 1'b0;
	endtask

	// Core is stopped, so nothing may move while loading
	task automatic load_program();
		for (int i = 0; i < prog.size(); i++)
		begin
			@(posedge ALU_CLK);
			#1;
			i_prog_we   = 1'b1;
			i_prog_addr = PROG_ADDR_W'(i);
			i_prog_data = prog[i];
			check_flag("o_io_we", o_io_we, 1'b0);
			check_pc("o_pc", o_pc, '0);
			check_sreg("o_sreg", o_sreg, '0);
		end
		@(posedge ALU_CLK);
		#1 i_prog_we = 1'b0;
	endtask

	task automatic run_program(input string name);
		int n_exec;
		int halt_pc;
		int cycles;
		n_exec      = run_model();
		halt_pc     = prog.size() - 1;
		cycle_limit = cycle_limit + 2 * n_exec;
		apply_reset();
		load_program();
		@(posedge ALU_CLK);
		#1 i_run = 1'b1;
		cycles = 0;
		do
		begin
			@(negedge ALU_CLK);
			cycles++;
		end
		while (o_pc != halt_pc);
		check_cycles({name, " cycles to halt"}, cycles, 2 * n_exec + 1);
		repeat (4)
			@(negedge ALU_CLK);
		if (exp_addr.size() != 0)
		begin
			$display("%s: %0d expected port writes never appeared", name, exp_addr.size());
			stop_on_error();
		end
		check_sreg("o_sreg", o_sreg, model_sreg);
		@(posedge ALU_CLK);
		#1 i_run = 1'b0;
	endtask

	// Port write monitor
	initial
	begin
		io_addr_t want_addr;
		data_t    want_data;
		sreg_t    want_sreg;
		forever
		begin
			@(negedge ALU_CLK);
			if (o_io_we)
			begin
				if (exp_addr.size() == 0)
				begin
					$display("Unexpected port write at %0t to %h with %h", $time, o_io_addr,
						o_io_data);
					stop_on_error();
				end
				want_addr = exp_addr.pop_front();
				want_data = exp_data.pop_front();
				want_sreg = exp_sreg.pop_front();
				check_io_addr("o_io_addr", o_io_addr, want_addr);
				check_data("o_io_data", o_io_data, want_data);
				check_sreg("o_sreg", o_sreg, want_sreg);
			end
		end
	end

	initial
	begin
		forever
		begin
			@(negedge ALU_CLK);
			if (i_run)
				total_cycles++;
			if (total_cycles > cycle_limit)
			begin
				$display("Timeout after %0d run cycles, a program never reached its end",
					total_cycles);
				stop_on_error();
			end
		end
	end

	initial
	begin
		hclk        = 1'b1;
		i_run       = 1'b0;
		i_prog_we   = 1'b0;
		i_prog_addr = '0;
		i_prog_data = '0;
		lfsr_state  = 32'had8;
		gen_alu_program();
		run_program("alu");
		gen_alu_program();
		run_program("alu2");
		gen_branch_program();
		run_program("branch");
		gen_nop_program();
		run_program("nop");
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== avr_core.f ====
hw/avr_pkg.sv
hw/prog_rom.sv
hw/op_decoder.sv
hw/reg_file.sv
hw/alu.sv
hw/core_ctrl.sv
hw/avr_core.sv
testbench/avr_core_tb.sv

// ==== Bender.yml ====
package:
  name: avr_core

sources:
  - hw/avr_pkg.sv
  - hw/prog_rom.sv
  - hw/op_decoder.sv
  - hw/reg_file.sv
  - hw/alu.sv
  - hw/core_ctrl.sv
  - hw/avr_core.sv
  - target: test
    files:
      - testbench/avr_core_tb.sv
